// File: Bender.yml
package:
  name: write_path

sources:
  - logic/wb_pkg.sv
  - logic/write_req_queue.sv
  - logic/axi_write_buffer.sv
  - logic/write_path_top.sv
  - target: test
    files:
      - testbench/tb_axi_mem.sv
      - testbench/tb_write_path.sv

// File: compile.f
logic/wb_pkg.sv
logic/write_req_queue.sv
logic/axi_write_buffer.sv
logic/write_path_top.sv
testbench/tb_axi_mem.sv
testbench/tb_write_path.sv

// File: logic/axi_write_buffer.sv
`timescale 1ns/1ps

module axi_write_buffer (
    input  logic             clk,
    input  logic             rst,

    // request queue side.
    input  wb_pkg::wr_req_t  head,
    input  logic             head_valid,
    output logic             pop,
    output logic             idle,

    // axi write channels.
    output wb_pkg::axi_aw_t  aw,
    output logic             awvalid,
    input  logic             awready,
    output wb_pkg::axi_w_t   w,
    output logic             wvalid,
    input  logic             wready,
    input  logic             bvalid,
    output logic             bready
);

    typedef enum logic [1:0] {
        s_idle,
        s_addr,
        s_data,
        s_resp
    } state_t;

    state_t                      state;
    wb_pkg::wr_req_t             req_q;     // request being written out.
    logic [wb_pkg::beat_w-1:0]   beat;
    logic                        last_beat;

    // ******************************
    // handshake outputs.
    // ******************************
    assign idle    = (state == s_idle);
    assign pop     = idle & head_valid;     // take the head whenever free.
    assign awvalid = (state == s_addr);
    assign wvalid  = (state == s_data);
    assign bready  = (state == s_resp);

    // a store is one beat, a line ends on its fourth.
    assign last_beat = req_q.uncached | (beat == (wb_pkg::line_beats - 1));

    // ******************************
    // channel payloads.
    // ******************************
    always_comb begin
        aw.addr = req_q.addr;
        aw.len  = req_q.uncached ? 8'd0 : 8'(wb_pkg::line_beats - 1);
        aw.size = req_q.uncached ? req_q.size : wb_pkg::beat_size;

        if (req_q.uncached) begin
            w.data = req_q.data;
            w.strb = req_q.wstrb;
        end else begin
            w.data = req_q.line[beat*32 +: 32];   // next word of the line.
            w.strb = 4'b1111;
        end
        w.last = last_beat;
    end

    // ******************************
    // transaction FSM.
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            beat  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (head_valid) begin
                        state <= s_addr;
                    end
                end
                s_addr: begin
                    if (awready) begin
                        state <= s_data;
                        beat  <= '0;
                    end
                end
                s_data: begin
                    if (wready) begin
                        if (last_beat) begin
                            state <= s_resp;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                s_resp: begin
                    if (bvalid) begin
                        state <= s_idle;    // bresp is not looked at.
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // capture the request as it leaves the queue.
    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= head;
        end
    end

    // ******************************
    // checks.
    // ******************************

    // address stays put until the slave takes it.
    assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw channel changed before awready");

    // data never leads the address.
    assert property (@(posedge clk) disable iff (rst)
        $rose(wvalid) |-> $past(awvalid && awready))
        else $error("wvalid raised without an address handshake");

    // last closes the burst and nothing follows it.
    assert property (@(posedge clk) disable iff (rst)
        wvalid && wready && w.last |=> !wvalid && bready)
        else $error("beat after wlast");

    // wlast lands on the beat that the burst length on aw promised.
    assert property (@(posedge clk) disable iff (rst)
        wvalid |-> w.last == (8'(beat) == aw.len))
        else $error("wlast does not match the burst length");

endmodule

// File: logic/wb_pkg.sv
package wb_pkg;

    // ******************************
    // cache line geometry.
    // ******************************
    localparam int line_bytes  = 16;
    localparam int line_beats  = line_bytes / 4;   // 32-bit beats per line.
    localparam int beat_w      = $clog2(line_beats);

    // eviction beats are always full words.
    localparam logic [2:0] beat_size = 3'b010;

    // ******************************
    // write request queue.
    // ******************************
    localparam int queue_depth = 4;                // power of two.
    localparam int queue_ptr_w = $clog2(queue_depth);

    // ******************************
    // request and bus payloads.
    // ******************************

    // one write request from the cache.
    typedef struct packed {
        logic                      uncached;
        logic [31:0]               addr;     // line aligned for evictions.
        logic [2:0]                size;
        logic [3:0]                wstrb;
        logic [31:0]               data;     // store word.
        logic [line_bytes*8-1:0]   line;     // beat 0 in the low word.
    } wr_req_t;

    // write address channel.
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_aw_t;

    // write data channel.
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

endpackage

// File: logic/write_path_top.sv
`timescale 1ns/1ps

module write_path_top (
    input  logic             clk,
    input  logic             rst,

    // cache side.
    input  wb_pkg::wr_req_t  req,
    input  logic             req_valid,
    output logic             req_ready,
    output logic             empty,

    // axi write channels.
    output wb_pkg::axi_aw_t  aw,
    output logic             awvalid,
    input  logic             awready,
    output wb_pkg::axi_w_t   w,
    output logic             wvalid,
    input  logic             wready,
    input  logic             bvalid,
    output logic             bready
);

    logic             push;
    logic             full;
    logic             pop;
    logic             idle;
    logic             head_valid;
    wb_pkg::wr_req_t  head;

    assign req_ready = ~full;
    assign push      = req_valid & req_ready;   // cache handshake.

    // all writes have left once nothing waits and the bus is quiet.
    assign empty = ~head_valid & idle;

    // ******************************
    // request queue.
    // ******************************
    write_req_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_req   (req),
        .pop        (pop),
        .full       (full),
        .head       (head),
        .head_valid (head_valid)
    );

    // ******************************
    // axi write buffer.
    // ******************************
    axi_write_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .idle       (idle),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule

// File: logic/write_req_queue.sv
`timescale 1ns/1ps

module write_req_queue (
    input  logic             clk,
    input  logic             rst,

    input  logic             push,
    input  wb_pkg::wr_req_t  push_req,
    input  logic             pop,

    output logic             full,
    output wb_pkg::wr_req_t  head,
    output logic             head_valid
);

    // request storage, no reset needed on the payload.
    wb_pkg::wr_req_t                 mem [wb_pkg::queue_depth];

    logic [wb_pkg::queue_ptr_w-1:0]  wr_ptr;
    logic [wb_pkg::queue_ptr_w-1:0]  rd_ptr;
    logic [wb_pkg::queue_ptr_w:0]    count;

    // ******************************
    // status and head.
    // ******************************
    assign full       = (count == wb_pkg::queue_depth);
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];    // oldest entry.

    // ******************************
    // pointers and occupancy.
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;         // idle, or push and pop together.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // ******************************
    // checks.
    // ******************************

    // the top must hold the cache off while full.
    assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("push into a full write queue");

    // the write buffer must only pop a valid head.
    assert property (@(posedge clk) disable iff (rst)
        pop |-> head_valid)
        else $error("pop from an empty write queue");

endmodule

// File: testbench/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter logic [31:0] seed_init = 32'h1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             hold_aw,    // keeps awready low.
    input  wb_pkg::axi_aw_t  aw,
    input  logic             awvalid,
    output logic             awready,
    input  wb_pkg::axi_w_t   w,
    input  logic             wvalid,
    output logic             wready,
    output logic             bvalid,
    input  logic             bready
);

    logic [7:0]       mem [4096];
    wb_pkg::axi_aw_t  aw_log [256];      // address transfers in arrival order.
    int               aw_count;
    integer           seed;
    logic [11:0]      beat_addr;
    logic             resp_due;
    logic             b_done;
    logic             hold;

    initial begin
        seed     = seed_init;
        aw_count = 0;
        resp_due = 1'b0;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 4);
        end
    end

    always @(posedge clk) begin
        hold   = hold_aw;
        b_done = bvalid && bready;
        if (awvalid && awready) begin
            aw_log[aw_count] = aw;
            aw_count         = aw_count + 1;
            beat_addr        = {aw.addr[11:2], 2'b00};
        end
        if (wvalid && wready) begin
            for (int k = 0; k < 4; k++) begin
                if (w.strb[k]) begin
                    mem[beat_addr + k] = w.data[8*k +: 8];    // byte lane k.
                end
            end
            beat_addr = beat_addr + 12'd4;
            resp_due  = resp_due | w.last;
        end
        #2;
        if (rst) begin
            awready  = 1'b0;
            wready   = 1'b0;
            bvalid   = 1'b0;
            resp_due = 1'b0;
        end else begin
            awready = !hold && (($random(seed) & 3) != 0);
            wready  = ($random(seed) & 3) != 0;
            if (b_done) begin
                bvalid = 1'b0;
            end else if (resp_due && !bvalid && ($random(seed) & 1)) begin
                bvalid   = 1'b1;    // held until bready.
                resp_due = 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_write_path.sv
`timescale 1ns/1ps

module tb_write_path;

    localparam logic [31:0] seed_value = 32'h36fa5f30;
    localparam int n_requests  = 50;     // store, eviction, 40 mixed, up to 8 held.
    localparam int cycle_limit = 60 * n_requests + 200;

    logic clk = 1'b0;
    logic rst, req_valid, req_ready, empty, hold_aw;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    wb_pkg::wr_req_t  req, cur;
    wb_pkg::axi_aw_t  aw;
    wb_pkg::axi_w_t   w;

    integer           seed = seed_value;
    logic [7:0]       mirror [4096];
    wb_pkg::wr_req_t  accepted [$];
    wb_pkg::wr_req_t  pending [$];    // accepted, address not yet seen.
    int beat_n, held, done_count, errors, checks, tests, test_errors, cycles;
    string test_name;

    write_path_top DUT (
        .clk(clk), .rst(rst), .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .empty(empty), .aw(aw), .awvalid(awvalid), .awready(awready), .w(w),
        .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready)
    );

    tb_axi_mem #(.seed_init(seed_value)) slave (
        .clk(clk), .rst(rst), .hold_aw(hold_aw), .aw(aw), .awvalid(awvalid),
        .awready(awready), .w(w), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped at the cycle limit with %s still running", test_name);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    // ******************************
    // beat and response monitor.
    // ******************************
    always @(posedge clk) begin
        if (!rst && awvalid && awready) begin
            if (pending.size() == 0) begin
                errors++;
                $display("%s: address transfer with no request waiting", test_name);
            end else begin
                cur    = pending.pop_front();
                beat_n = 0;
            end
        end
        if (!rst && wvalid && wready) begin
            check_value("wdata", cur.uncached ? cur.data : cur.line[beat_n*32 +: 32], w.data);
            check_value("wstrb", cur.uncached ? cur.wstrb : 4'hf, w.strb);
            check_value("wlast", cur.uncached || beat_n == wb_pkg::line_beats - 1, w.last);
            beat_n++;
        end
        if (!rst && bvalid && bready) begin
            check_value("beats", cur.uncached ? 1 : wb_pkg::line_beats, beat_n);
            done_count++;
        end
    end

    function automatic wb_pkg::wr_req_t random_request(input logic uncached);
        wb_pkg::wr_req_t r;
        logic [1:0]      ofs;
        r.uncached = uncached;
        r.data     = $random(seed);
        for (int k = 0; k < wb_pkg::line_beats; k++) begin
            r.line[32*k +: 32] = $random(seed);
        end
        if (uncached) begin
            r.size  = 3'(($random(seed) & 32'h7fff_ffff) % 3);
            ofs     = 2'($random(seed)) & ~2'((1 << r.size) - 1);    // aligned to size.
            r.addr  = ($random(seed) & 32'hffc) | ofs;
            r.wstrb = 4'(((1 << (1 << r.size)) - 1) << ofs);
        end else begin
            r.size  = 3'd2;
            r.addr  = $random(seed) & 32'hff0;
            r.wstrb = 4'hf;
        end
        return r;
    endfunction

    // record a request taken by the DUT and apply it to the mirror.
    task automatic accept(input wb_pkg::wr_req_t r);
        accepted.push_back(r);
        pending.push_back(r);
        for (int b = 0; b < wb_pkg::line_bytes; b++) begin
            if (!r.uncached) begin
                mirror[r.addr[11:0] + b] = r.line[8*b +: 8];
            end else if (b < 4 && r.wstrb[b]) begin
                mirror[{r.addr[11:2], 2'b00} + b] = r.data[8*b +: 8];
            end
        end
    endtask

    task automatic send_request(input wb_pkg::wr_req_t r);
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        accept(r);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain;
        @(negedge clk);
        while (!empty) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic check_results;
        check_value("address transfers", accepted.size(), slave.aw_count);
        for (int i = 0; i < accepted.size() && i < slave.aw_count; i++) begin
            check_value("awaddr", accepted[i].addr, slave.aw_log[i].addr);
            check_value("awlen", accepted[i].uncached ? 0 : 3, slave.aw_log[i].len);
            check_value("awsize", accepted[i].size, slave.aw_log[i].size);
        end
        for (int i = 0; i < 4096; i++) begin
            check_value($sformatf("mem[%0h]", i), mirror[i], slave.mem[i]);
        end
    endtask

    task automatic end_test;
        tests++;
        $display("%-14s finished, %0d errors", test_name, errors - test_errors);
        test_errors = errors;
    endtask

    // ******************************
    // test sequence.
    // ******************************
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mirror[i] = 8'(i) ^ 8'(i >> 4);    // same fill as the slave.
        end
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        hold_aw = 1'b0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        check_value("awvalid", 0, awvalid);
        check_value("wvalid", 0, wvalid);
        check_value("bready", 0, bready);
        check_value("req_ready", 1, req_ready);
        check_value("empty", 1, empty);
        end_test();

        test_name = "store";
        send_request(random_request(1'b1));
        wait_drain();
        check_results();
        end_test();

        test_name = "eviction";
        send_request(random_request(1'b0));
        wait_drain();
        check_results();
        end_test();

        test_name = "ordering";
        repeat (40) send_request(random_request(1'($random(seed))));
        wait_drain();
        check_results();
        end_test();

        // one request parks on the bus, the queue fills behind it.
        test_name = "backpressure";
        hold_aw = 1'b1;
        req = random_request(1'($random(seed)));
        req_valid = 1'b1;
        @(posedge clk);
        while (req_ready && held < 8) begin
            accept(req);
            held++;
            #2;
            req = random_request(1'($random(seed)));
            @(posedge clk);
        end
        check_value("accepted while held", wb_pkg::queue_depth + 1, held);
        #2;
        req_valid = 1'b0;
        hold_aw = 1'b0;
        wait_drain();
        check_results();
        end_test();

        test_name = "completion";
        check_value("completed", accepted.size(), done_count);
        check_value("left over", 0, pending.size());
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
